// ==== list.f ====
+incdir+source
source/csr_isa_pkg.sv
source/csr_trap_pkg.sv
source/sys_decode.sv
source/csr_file.sv
source/trap_ctrl.sv
source/csr_unit_top.sv
sim/csr_unit_checker.sv
sim/csr_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the csr unit testbench with verilator, run it and scan the output
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f list.f --top-module csr_unit_tb -Mdir obj_dir

result=$(./obj_dir/Vcsr_unit_tb)
printf '%s\n' "$result"

if grep -qx "Test completed successfully" <<< "$result"; then
    exit 0
else
    exit 1
fi

// ==== sim/csr_unit_tests.txt ====
// columns: instr rs1_data pc irq | expected rd_we rd_data redirect redirect_pc
// one test per line in hex, applied in order with state carried from line to line
300090F3 00000000 00000000 0  1 00000000 0 00000000  // mstatus reads zero
305090F3 00000000 00000000 0  1 00000000 0 00000000  // mtvec
341090F3 00000000 00000000 0  1 00000000 0 00000000  // mepc
342090F3 00000000 00000000 0  1 00000000 0 00000000  // mcause
344090F3 00000000 00000000 0  1 00000000 0 00000000  // mip
305090F3 80000103 00000000 0  1 00000000 0 00000000  // mtvec pattern
305090F3 80000100 00000000 0  1 80000100 0 00000000  // low bits cleared
341090F3 12345677 00000000 0  1 00000000 0 00000000
341090F3 00000000 00000000 0  1 12345674 0 00000000
34209073 A5A5A5A5 00000000 0  0 00000000 0 00000000  // rd x0 no writeback
342090F3 00000000 00000000 0  1 A5A5A5A5 0 00000000
342AD173 FFFFFFFF 00000000 0  1 00000000 0 00000000  // csrrwi imm 0x15
342090F3 00000000 00000000 0  1 00000015 0 00000000
00000073 00000000 00001004 0  0 00000000 1 80000100  // ecall
342090F3 00000000 00000000 0  1 0000000B 0 00000000
341090F3 00001004 00000000 0  1 00001004 0 00000000
00100073 00000000 0000200A 0  0 00000000 1 80000100  // ebreak, pc low bits dropped
342090F3 00000000 00000000 0  1 00000003 0 00000000
300090F3 00000008 00000000 0  1 00000000 0 00000000  // set mie
00000073 00000000 00003000 0  0 00000000 1 80000100
30200073 00000000 00000000 0  0 00000000 1 00003000  // mret
300090F3 00000008 00000000 0  1 00000088 0 00000000  // mie and mpie set
305090F3 DEADBEEF 00004004 1  0 00000000 1 80000100  // irq wins, write dropped
342090F3 00000000 00000000 1  1 8000000B 0 00000000  // mie clear so irq ignored
344090F3 00000000 00000000 1  1 00000800 0 00000000  // meip pending
340090F3 00000055 00005000 0  0 00000000 1 80000100  // unknown csr
342090F3 00000000 00000000 0  1 00000002 0 00000000
3000A0F3 00000000 00005010 0  0 00000000 1 80000100  // csrrs funct3
342090F3 00000000 00000000 0  1 00000002 0 00000000
10500073 00000000 00005020 0  0 00000000 1 80000100  // wfi
342090F3 00000000 00000000 0  1 00000002 0 00000000
341090F3 00000000 00000000 0  1 00005020 0 00000000

// ==== sim/csr_unit_tb.sv ====
// csr unit testbench that replays the test table against the dut on falling edges
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_unit_tb;

    localparam int max_tests = 64;
    localparam int fields    = 8;           // words per table line

    logic             clk;
    logic             arst_n;
    logic             instr_valid;
    logic [31:0]      instr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] pc;
    logic             irq;
    logic             rd_we;
    logic [4:0]       rd_addr;
    logic [`XLEN-1:0] rd_data;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;

    // expected values handed to the checker with each strobe
    logic             exp_rd_we;
    logic [4:0]       exp_rd_addr;          // rd field of the instruction
    logic [`XLEN-1:0] exp_rd_data;
    logic             exp_redirect;
    logic [`XLEN-1:0] exp_redirect_pc;
    int               test_idx;
    int               checked;
    int               errors;

    logic [31:0]      table_mem [0:max_tests*fields-1];
    int               num_tests;
    logic             loaded;
    int               limit_cycles;

    csr_unit_top u_csr_unit_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .irq         (irq),
        .rd_we       (rd_we),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    csr_unit_checker u_checker (
        .clk             (clk),
        .arst_n          (arst_n),
        .instr_valid     (instr_valid),
        .test_idx        (test_idx),
        .exp_rd_we       (exp_rd_we),
        .exp_rd_addr     (exp_rd_addr),
        .exp_rd_data     (exp_rd_data),
        .exp_redirect    (exp_redirect),
        .exp_redirect_pc (exp_redirect_pc),
        .rd_we           (rd_we),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .checked         (checked),
        .errors          (errors)
    );

    always #10 clk = ~clk;                  // 20 ns period

    task automatic load_tests();
        int t;
        for (int a = 0; a < max_tests * fields; a++) begin
            table_mem[a] = 32'hBAD0_0000 | a;   // unused words never pass as an irq bit
        end
        $readmemh("sim/csr_unit_tests.txt", table_mem);
        t = 0;
        // a line exists while its irq column holds 0 or 1
        while (t < max_tests && table_mem[t*fields+3] <= 32'd1) begin
            t++;
        end
        num_tests = t;
    endtask

    task automatic apply_test(input int i);
        int b;
        b               = i * fields;
        instr           = table_mem[b];
        rs1_data        = table_mem[b+1];
        pc              = table_mem[b+2];
        irq             = table_mem[b+3][0];    // irq level holds until the next line
        exp_rd_we       = table_mem[b+4][0];
        exp_rd_addr     = table_mem[b][11:7];
        exp_rd_data     = table_mem[b+5];
        exp_redirect    = table_mem[b+6][0];
        exp_redirect_pc = table_mem[b+7];
        test_idx        = i + 1;                // numbered like the table lines
        instr_valid     = 1'b1;
    endtask

    initial begin
        clk             = 1'b0;
        arst_n          = 1'b0;
        instr_valid     = 1'b0;
        instr           = '0;
        rs1_data        = '0;
        pc              = '0;
        irq             = 1'b0;
        exp_rd_we       = 1'b0;
        exp_rd_addr     = '0;
        exp_rd_data     = '0;
        exp_redirect    = 1'b0;
        exp_redirect_pc = '0;
        test_idx        = 0;
        loaded          = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < num_tests; i++) begin
            @(negedge clk);
            apply_test(i);
            @(negedge clk);
            instr_valid = 1'b0;             // one cycle strobe
            wait (checked == i + 1);
        end
        @(negedge clk);
        $display("%0d tests, %0d checked, %0d errors", num_tests, checked, errors);
        if (errors == 0 && checked == num_tests && num_tests > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (loaded);
        limit_cycles = 16 + 2 * num_tests + 20;
        repeat (limit_cycles) @(posedge clk);
        $display("timeout after %0d cycles with %0d of %0d tests checked",
                 limit_cycles, checked, num_tests);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== sim/csr_unit_checker.sv ====
// csr unit output checker that compares writeback and redirect with the expected values
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_unit_checker (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             instr_valid,
    input  int               test_idx,
    input  logic             exp_rd_we,
    input  logic [4:0]       exp_rd_addr,
    input  logic [`XLEN-1:0] exp_rd_data,
    input  logic             exp_redirect,
    input  logic [`XLEN-1:0] exp_redirect_pc,
    input  logic             rd_we,
    input  logic [4:0]       rd_addr,
    input  logic [`XLEN-1:0] rd_data,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    output int               checked,
    output int               errors
);
    logic             pending;     // a strobe was taken at the last rising edge
    int               idx_q;
    logic             we_q;
    logic [4:0]       addr_q;
    logic [`XLEN-1:0] data_q;
    logic             redir_q;
    logic [`XLEN-1:0] pc_q;
    int               n_checked = 0;
    int               n_errors  = 0;

    assign checked = n_checked;
    assign errors  = n_errors;

    function automatic int field_mismatch(string name, int idx, logic [31:0] expv,
                                          logic [31:0] actv);
        if (expv !== actv) begin
            $display("FAIL test %0d %s expected %h got %h", idx, name, expv, actv);
            return 1;
        end
        return 0;
    endfunction

    // expectations travel with the strobe
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            idx_q   <= 0;
            we_q    <= 1'b0;
            addr_q  <= '0;
            data_q  <= '0;
            redir_q <= 1'b0;
            pc_q    <= '0;
        end else begin
            pending <= instr_valid;
            if (instr_valid) begin
                idx_q   <= test_idx;
                we_q    <= exp_rd_we;
                addr_q  <= exp_rd_addr;
                data_q  <= exp_rd_data;
                redir_q <= exp_redirect;
                pc_q    <= exp_redirect_pc;
            end
        end
    end

    // outputs settled half a cycle after the edge that registered them
    always @(negedge clk) begin
        int bad;
        if (pending) begin
            bad = 0;
            bad += field_mismatch("rd_we", idx_q, {31'd0, we_q}, {31'd0, rd_we});
            if (we_q) begin
                // destination only matters with a writeback
                bad += field_mismatch("rd_addr", idx_q, {27'd0, addr_q}, {27'd0, rd_addr});
            end
            bad += field_mismatch("rd_data", idx_q, data_q, rd_data);
            bad += field_mismatch("redirect", idx_q, {31'd0, redir_q}, {31'd0, redirect});
            bad += field_mismatch("redirect_pc", idx_q, pc_q, redirect_pc);
            if (bad == 0) begin
                $display("test %0d ok", idx_q);
            end
            n_errors  = n_errors + bad;
            n_checked = n_checked + 1;          // releases the stimulus loop
        end
    end

endmodule

// ==== source/csr_unit_top.sv ====
// csr unit top level joining system decode, csr file and trap control
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_unit_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             instr_valid,   // one cycle strobe
    input  logic [31:0]      instr,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] pc,
    input  logic             irq,           // level
    output logic             rd_we,
    output logic [4:0]       rd_addr,
    output logic [`XLEN-1:0] rd_data,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_pc
);
    import csr_isa_pkg::*;
    import csr_trap_pkg::*;

    // decode to csr file and trap control
    sys_op_e          op;
    logic [11:0]      csr_addr;
    logic [`XLEN-1:0] wdata;
    logic [4:0]       dec_rd_addr;

    // csr file to trap control
    logic [`XLEN-1:0] rdata;
    logic             csr_hit;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic             mie;

    // trap control back to csr file
    trap_kind_e       kind;
    cause_e           cause;

    sys_decode u_sys_decode (
        .instr    (instr),
        .rs1_data (rs1_data),
        .op       (op),
        .csr_addr (csr_addr),
        .wdata    (wdata),
        .rd_addr  (dec_rd_addr)
    );

    csr_file u_csr_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .irq      (irq),
        .csr_addr (csr_addr),
        .wdata    (wdata),
        .pc       (pc),
        .kind     (kind),
        .cause    (cause),
        .rdata    (rdata),
        .csr_hit  (csr_hit),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .mie      (mie)
    );

    trap_ctrl u_trap_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .op          (op),
        .csr_hit     (csr_hit),
        .irq         (irq),
        .mie         (mie),
        .rdata       (rdata),
        .rd_addr_in  (dec_rd_addr),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .kind        (kind),
        .cause       (cause),
        .rd_we       (rd_we),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

// ==== source/trap_ctrl.sv ====
// trap control that arbitrates interrupt, exception, return and csr write and registers outputs
`timescale 1ns/10ps
`include "csr_cfg.svh"

module trap_ctrl (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     instr_valid,
    input  csr_isa_pkg::sys_op_e     op,
    input  logic                     csr_hit,
    input  logic                     irq,
    input  logic                     mie,
    input  logic [`XLEN-1:0]         rdata,
    input  logic [4:0]               rd_addr_in,
    input  logic [`XLEN-1:0]         mtvec,
    input  logic [`XLEN-1:0]         mepc,
    output csr_trap_pkg::trap_kind_e kind,
    output csr_trap_pkg::cause_e     cause,
    output logic                     rd_we,
    output logic [4:0]               rd_addr,
    output logic [`XLEN-1:0]         rd_data,
    output logic                     redirect,
    output logic [`XLEN-1:0]         redirect_pc
);
    import csr_isa_pkg::*;
    import csr_trap_pkg::*;

    logic is_csr;
    logic wb_en;       // write with a real destination

    assign is_csr = (op == op_csrrw) || (op == op_csrrwi);
    assign wb_en  = (kind == tk_write) && (rd_addr_in != 5'd0);

    // interrupt first, then illegal, then the operation itself
    always_comb begin
        kind  = tk_idle;
        cause = cs_illegal;
        if (instr_valid) begin
            if (irq && mie) begin
                kind  = tk_trap;               // instruction is dropped
                cause = cs_irq;
            end else if (op == op_illegal || (is_csr && !csr_hit)) begin
                kind  = tk_trap;
            end else begin
                case (op)
                    op_ecall: begin
                        kind  = tk_trap;
                        cause = cs_ecall;
                    end
                    op_ebreak: begin
                        kind  = tk_trap;
                        cause = cs_break;
                    end
                    op_mret:   kind = tk_return;
                    op_csrrw,
                    op_csrrwi: kind = tk_write;
                    default:   kind = tk_idle;  // op_none
                endcase
            end
        end
    end

    // one register stage towards the core
    // idle fields read back as zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_we       <= 1'b0;
            rd_addr     <= '0;
            rd_data     <= '0;
            redirect    <= 1'b0;
            redirect_pc <= '0;
        end else begin
            rd_we       <= wb_en;
            rd_addr     <= wb_en ? rd_addr_in : 5'd0;
            rd_data     <= wb_en ? rdata : '0;        // old csr value
            redirect    <= (kind == tk_trap) || (kind == tk_return);
            redirect_pc <= (kind == tk_trap)   ? mtvec :
                           (kind == tk_return) ? mepc  : '0;
        end
    end

    // one action per instruction
    a_one_action: assert property (@(posedge clk) disable iff (!arst_n) !(rd_we && redirect))
        else $error("trap_ctrl writeback and redirect together");

endmodule

// ==== source/csr_file.sv ====
// machine mode csr file holding mstatus, mtvec, mepc, mcause and mip with trap updates
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_file (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     irq,
    input  logic [11:0]              csr_addr,
    input  logic [`XLEN-1:0]         wdata,
    input  logic [`XLEN-1:0]         pc,
    input  csr_trap_pkg::trap_kind_e kind,
    input  csr_trap_pkg::cause_e     cause,
    output logic [`XLEN-1:0]         rdata,
    output logic                     csr_hit,
    output logic [`XLEN-1:0]         mtvec,
    output logic [`XLEN-1:0]         mepc,
    output logic                     mie
);
    import csr_trap_pkg::*;

    logic [`XLEN-1:0] mstatus;     // only mie and mpie have an effect
    logic [`XLEN-1:0] mcause;
    logic             mip_meip;    // mip is just the sampled irq
    logic [`XLEN-1:0] mip;
    logic [`XLEN-1:0] cause_word;

    assign mie = mstatus[`MSTATUS_MIE];

    // mip view
    always_comb begin
        mip = '0;
        mip[`MIP_MEIP] = mip_meip;
    end

    // selector to mcause word
    always_comb begin
        case (cause)
            cs_illegal: cause_word = `CAUSE_ILLEGAL;
            cs_break:   cause_word = `CAUSE_BREAK;
            cs_ecall:   cause_word = `CAUSE_ECALL;
            default:    cause_word = `CAUSE_EXT_IRQ;   // cs_irq
        endcase
    end

    // read mux and address hit
    always_comb begin
        csr_hit = 1'b1;
        case (csr_addr)
            `CSR_MSTATUS: rdata = mstatus;
            `CSR_MTVEC:   rdata = mtvec;
            `CSR_MEPC:    rdata = mepc;
            `CSR_MCAUSE:  rdata = mcause;
            `CSR_MIP:     rdata = mip;
            default: begin
                rdata   = '0;
                csr_hit = 1'b0;            // trap control raises illegal
            end
        endcase
    end

    // register updates land at the edge of the strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mip_meip <= 1'b0;
        end else begin
            mip_meip <= irq;               // follows the line every cycle
            case (kind)
                tk_write: begin
                    case (csr_addr)
                        `CSR_MSTATUS: mstatus <= wdata;
                        `CSR_MTVEC:   mtvec   <= {wdata[`XLEN-1:2], 2'b00};  // direct mode
                        `CSR_MEPC:    mepc    <= {wdata[`XLEN-1:2], 2'b00};
                        `CSR_MCAUSE:  mcause  <= wdata;
                        default: ;                 // mip read only
                    endcase
                end
                tk_trap: begin
                    mepc   <= {pc[`XLEN-1:2], 2'b00};
                    mcause <= cause_word;
                    mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];  // stack the enable
                    mstatus[`MSTATUS_MIE]  <= 1'b0;
                end
                tk_return: begin
                    mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE]; // pop the enable
                    mstatus[`MSTATUS_MPIE] <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    // trap and return targets stay word aligned
    a_vec_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        mtvec[1:0] == 2'b00 && mepc[1:0] == 2'b00)
        else $error("csr_file mtvec or mepc misaligned");

    // trap control must never commit a write to a missing csr
    a_write_hit: assert property (@(posedge clk) disable iff (!arst_n)
        kind == tk_write |-> csr_hit)
        else $error("csr_file write to unknown csr %h", csr_addr);

endmodule

// ==== source/sys_decode.sv ====
// system instruction decoder that classifies csr, trap and return operations
`timescale 1ns/10ps
`include "csr_cfg.svh"

module sys_decode (
    input  logic [31:0]          instr,
    input  logic [`XLEN-1:0]     rs1_data,
    output csr_isa_pkg::sys_op_e op,
    output logic [11:0]          csr_addr,
    output logic [`XLEN-1:0]     wdata,
    output logic [4:0]           rd_addr
);
    import csr_isa_pkg::*;

    // imm field values of the priv functions
    localparam logic [11:0] imm_ecall  = 12'h000;
    localparam logic [11:0] imm_ebreak = 12'h001;
    localparam logic [11:0] imm_mret   = 12'h302;

    logic [6:0]  opcode;
    funct3_e     funct3;
    logic [4:0]  rs1;     // register index or 5 bit immediate
    logic [11:0] imm;

    // instruction fields
    assign opcode   = instr[6:0];
    assign funct3   = funct3_e'(instr[14:12]);
    assign rs1      = instr[19:15];
    assign imm      = instr[31:20];
    assign rd_addr  = instr[11:7];
    assign csr_addr = imm;    // csr number sits in the i-type imm slot

    // operation classification
    always_comb begin
        op = op_none;                       // other opcodes pass untouched
        if (opcode == opc_system) begin
            case (funct3)
                f3_csrrw: begin
                    op = op_csrrw;
                end
                f3_csrrwi: begin
                    op = op_csrrwi;
                end
                f3_priv: begin
                    // priv functions need rs1 and rd zero
                    if (rs1 != 5'd0 || rd_addr != 5'd0) begin
                        op = op_illegal;
                    end else begin
                        case (imm)
                            imm_ecall:  op = op_ecall;
                            imm_ebreak: op = op_ebreak;
                            imm_mret:   op = op_mret;
                            default:    op = op_illegal;  // wfi, sret and others
                        endcase
                    end
                end
                default: begin
                    op = op_illegal;                      // csrrs, csrrc and reserved
                end
            endcase
        end
    end

    // write operand
    // csrrwi zero extends the rs1 field
    assign wdata = (op == op_csrrwi) ? {{(`XLEN-5){1'b0}}, rs1} : rs1_data;

    // a known instruction word must always decode to a known operation
    a_op_known: assert property (@(instr) !$isunknown(instr) |-> !$isunknown(op))
        else $error("sys_decode op unknown for instr %h", instr);

endmodule

// ==== source/csr_trap_pkg.sv ====
// trap side types for the trap control and cause selection of the csr unit
package csr_trap_pkg;

    // action strobe from trap control to the csr file
    typedef enum logic [1:0] {
        tk_idle   = 2'd0,   // nothing to do this cycle
        tk_trap   = 2'd1,   // save pc and cause then jump to mtvec
        tk_return = 2'd2,   // mret
        tk_write  = 2'd3    // csr write with old value to rd
    } trap_kind_e;

    // cause selector
    // the csr file turns this into the full mcause word
    typedef enum logic [1:0] {
        cs_illegal = 2'd0,
        cs_break   = 2'd1,
        cs_ecall   = 2'd2,
        cs_irq     = 2'd3   // external interrupt
    } cause_e;

endpackage

// ==== source/csr_isa_pkg.sv ====
// instruction side types for the system opcode decode of the csr unit
package csr_isa_pkg;

    // major opcode shared by every system instruction
    localparam logic [6:0] opc_system = 7'b1110011;

    // decoded system operation
    typedef enum logic [2:0] {
        op_none    = 3'd0,  // not a system instruction
        op_csrrw   = 3'd1,
        op_csrrwi  = 3'd2,
        op_ecall   = 3'd3,
        op_ebreak  = 3'd4,
        op_mret    = 3'd5,
        op_illegal = 3'd6
    } sys_op_e;

    // funct3 field of the system opcode
    // csrrs and csrrc variants are not supported
    typedef enum logic [2:0] {
        f3_priv   = 3'd0,   // ecall ebreak mret
        f3_csrrw  = 3'd1,
        f3_csrrwi = 3'd5
    } funct3_e;

endpackage

// ==== source/csr_cfg.svh ====
// csr unit configuration with data width, csr addresses, cause words and status bit positions
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define XLEN 32

// machine mode csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MIP     12'h344

`define MSTATUS_MIE  3     // global interrupt enable
`define MSTATUS_MPIE 7     // enable saved on trap
`define MIP_MEIP     11    // external interrupt pending

// full mcause words
`define CAUSE_ILLEGAL 32'h0000_0002
`define CAUSE_BREAK   32'h0000_0003
`define CAUSE_ECALL   32'h0000_000B
`define CAUSE_EXT_IRQ 32'h8000_000B  // msb marks an interrupt

`endif
